/* compile.f */
hw/dma_pkg.sv
hw/dma_stream_stage.sv
hw/dma_regs.sv
hw/dma_engine_fsm.sv
hw/dma_transfer_counter.sv
hw/dma_s2c_path.sv
hw/dma_top.sv
tests/dma_assertions.sv
tests/dma_checker.sv
tests/dma_tb.sv

/* hw/dma_engine_fsm.sv */
/*
  DMA engine sequencer
  Runs a descriptor once enabled, then waits for requester ready before ending
*/
`timescale 1ns/10ps

module dma_engine_fsm import dma_pkg::*; (
  input  logic CLK,
  input  logic dma_reset_n,
  input  logic engine_enable,
  input  logic enable_write,
  input  logic size_reached,
  input  logic rq_tready,
  output logic running,
  output logic done_pulse,
  output logic operation_in_course
);

  engine_state_t state_r, state_nx;
  logic          stopped_r;  // Local copy of the status stopped bit

  always_comb begin
    state_nx = state_r;
    case (state_r)
      state_idle:  if (engine_enable && !stopped_r) state_nx = state_run;
      state_run:   if (size_reached) state_nx = state_drain;
      state_drain: if (rq_tready) state_nx = state_idle;  // Requester must be ready first
      default:     state_nx = state_idle;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!dma_reset_n) begin
      state_r <= state_idle;
    end else begin
      state_r <= state_nx;
    end
  end

  // Blocks a restart until software enables again
  always_ff @(posedge CLK) begin
    if (!dma_reset_n) begin
      stopped_r <= 1'b0;
    end else if (enable_write) begin
      stopped_r <= 1'b0;
    end else if (done_pulse) begin
      stopped_r <= 1'b1;
    end
  end

  assign done_pulse          = (state_r == state_drain) & rq_tready;
  assign running             = (state_r == state_run);
  assign operation_in_course = (state_r != state_idle);

endmodule

/* hw/dma_pkg.sv */
/*
  DMA front end shared definitions
  Stream and register widths, register map, bit positions, beat types and FSM states
*/
package dma_pkg;

  // Stream widths
  localparam int bus_data_w   = 256;
  localparam int byte_keep_w  = 32;
  localparam int dword_keep_w = 8;
  localparam int keep_cnt_w   = $clog2(byte_keep_w + 1);

  // Register window widths
  localparam int addr_w     = 16;
  localparam int reg_data_w = 64;

  //////////////////////
  // Register map
  localparam logic [addr_w-1:0] engine_base       = 16'h0200;
  localparam logic [addr_w-1:0] engine_spacing    = 16'h2000;
  localparam logic [addr_w-1:0] engine_ctrl_addr  = engine_base + 16'h0000;
  localparam logic [addr_w-1:0] engine_size_addr  = engine_base + 16'h0008;
  localparam logic [addr_w-1:0] engine_count_addr = engine_base + 16'h0010;
  localparam logic [addr_w-1:0] global_reg_addr   = engine_base + engine_spacing;

  // Status byte and global register bits
  localparam int st_enable_bit     = 0;
  localparam int st_stopped_bit    = 3;
  localparam int st_irq_bit        = 7;
  localparam int gl_irq_en_bit     = 6;
  localparam int gl_soft_reset_bit = 7;

  // Read-only capability codes, log2 minus 7
  localparam int log2_max_payload      = 8;
  localparam int log2_max_read_request = 12;
  localparam logic [2:0] max_payload_code      = 3'(log2_max_payload - 7);
  localparam logic [2:0] max_read_request_code = 3'(log2_max_read_request - 7);

  //////////////////////
  // Beat payloads
  typedef struct packed {
    logic [bus_data_w-1:0]  data;
    logic [byte_keep_w-1:0] keep;
    logic                   last;
  } c2s_beat_t;

  typedef struct packed {
    logic [bus_data_w-1:0]   data;
    logic [dword_keep_w-1:0] keep;  // One bit per dword
    logic                    last;
  } rc_beat_t;

  typedef enum logic [1:0] {
    state_idle  = 2'd0,
    state_run   = 2'd1,
    state_drain = 2'd2
  } engine_state_t;

endpackage

/* hw/dma_regs.sv */
/*
  DMA register window
  Engine descriptor and status, global control, one-cycle acked reads
  and the self-clearing soft reset that drives the core reset
*/
`timescale 1ns/10ps

module dma_regs import dma_pkg::*; (
  input  logic                    CLK,
  input  logic                    dma_reset_n,
  input  logic                    mem_en,
  input  logic [addr_w-1:0]       mem_addr,
  input  logic [reg_data_w-1:0]   mem_din,
  input  logic [reg_data_w/8-1:0] mem_we,
  input  logic                    done_pulse,
  input  logic [reg_data_w-1:0]   byte_count,
  output logic [reg_data_w-1:0]   mem_dout,
  output logic                    mem_ack,
  output logic                    core_reset_n,
  output logic                    engine_enable,
  output logic                    enable_write,
  output logic [reg_data_w-1:0]   descriptor_size,
  output logic                    irq_enable,
  output logic                    irq
);

  logic                  wr;
  logic                  sel_ctrl, sel_size, sel_count, sel_global;
  logic                  mapped;
  logic                  soft_reset_r;
  logic                  stopped_r;
  logic                  irq_pending_r;
  logic [7:0]            status_byte;
  logic [reg_data_w-1:0] rd_data;

  assign wr         = mem_en & (|mem_we);  // Any byte enable makes it a write
  assign sel_ctrl   = (mem_addr == engine_ctrl_addr);
  assign sel_size   = (mem_addr == engine_size_addr);
  assign sel_count  = (mem_addr == engine_count_addr);
  assign sel_global = (mem_addr == global_reg_addr);
  assign mapped     = sel_ctrl | sel_size | sel_count | sel_global;

  assign enable_write = wr & sel_ctrl & mem_we[0] & mem_din[st_enable_bit];

  //////////////////////
  // Soft reset, only the external reset clears it
  always_ff @(posedge CLK) begin
    if (!dma_reset_n) begin
      soft_reset_r <= 1'b0;
    end else begin
      soft_reset_r <= wr & sel_global & mem_we[0] & mem_din[gl_soft_reset_bit];
    end
  end

  assign core_reset_n = dma_reset_n & ~soft_reset_r;

  //////////////////////
  // Engine and global control
  always_ff @(posedge CLK) begin
    if (!core_reset_n) begin
      engine_enable   <= 1'b0;
      stopped_r       <= 1'b0;
      irq_pending_r   <= 1'b0;
      irq_enable      <= 1'b0;
      descriptor_size <= '0;
    end else begin
      if (done_pulse) begin
        stopped_r     <= 1'b1;
        irq_pending_r <= 1'b1;
      end
      if (wr && sel_ctrl && mem_we[0]) begin
        engine_enable <= mem_din[st_enable_bit];
        if (mem_din[st_enable_bit])
          stopped_r <= 1'b0;  // Restart the descriptor
        if (mem_din[st_irq_bit])
          irq_pending_r <= 1'b0;  // Write 1 to clear
      end
      if (wr && sel_global && mem_we[0])
        irq_enable <= mem_din[gl_irq_en_bit];
      for (int i = 0; i < reg_data_w / 8; i++) begin
        if (wr && sel_size && mem_we[i])
          descriptor_size[8*i +: 8] <= mem_din[8*i +: 8];
      end
    end
  end

  always_comb begin
    status_byte                 = '0;
    status_byte[st_enable_bit]  = engine_enable;
    status_byte[st_stopped_bit] = stopped_r;
    status_byte[st_irq_bit]     = irq_pending_r;
  end

  // Read data mux
  always_comb begin
    rd_data = '0;
    if (sel_ctrl)
      rd_data[7:0] = status_byte;
    else if (sel_size)
      rd_data = descriptor_size;
    else if (sel_count)
      rd_data = byte_count;
    else if (sel_global)
      rd_data[7:0] = {1'b0, irq_enable, max_read_request_code, max_payload_code};
  end

  always_ff @(posedge CLK) begin
    if (!core_reset_n) begin
      mem_ack <= 1'b0;
    end else begin
      mem_ack <= mem_en & mapped;  // Unmapped addresses stay silent
    end
  end

  always_ff @(posedge CLK) begin
    if (mem_en)
      mem_dout <= rd_data;
  end

  assign irq = irq_pending_r & irq_enable;

endmodule

/* hw/dma_s2c_path.sv */
/*
  S2C completion path
  Registers completion beats and widens dword keep to byte keep on the last beat
*/
`timescale 1ns/10ps

module dma_s2c_path import dma_pkg::*; (
  input  logic                    CLK,
  input  logic                    dma_reset_n,
  input  logic [bus_data_w-1:0]   rc_tdata,
  input  logic [dword_keep_w-1:0] rc_tkeep,
  input  logic                    rc_tlast,
  input  logic                    rc_tvalid,
  output logic                    rc_tready,
  output logic [bus_data_w-1:0]   s2c_tdata,
  output logic [byte_keep_w-1:0]  s2c_tkeep,
  output logic                    s2c_tlast,
  output logic                    s2c_tvalid,
  input  logic                    s2c_tready
);

  rc_beat_t               rc_in, rc_out;
  logic [byte_keep_w-1:0] keep_wide;

  assign rc_in = '{data: rc_tdata, keep: rc_tkeep, last: rc_tlast};

  dma_stream_stage #(.payload_t(rc_beat_t)) rc_stage_i (
    .CLK        (CLK),
    .dma_reset_n(dma_reset_n),
    .in_data    (rc_in),
    .in_valid   (rc_tvalid),
    .in_ready   (rc_tready),
    .out_data   (rc_out),
    .out_valid  (s2c_tvalid),
    .out_ready  (s2c_tready)
  );

  always_comb begin
    for (int i = 0; i < dword_keep_w; i++)
      keep_wide[4*i +: 4] = {4{rc_out.keep[i]}};  // One dword is four bytes
  end

  assign s2c_tdata = rc_out.data;
  assign s2c_tlast = rc_out.last;
  assign s2c_tkeep = rc_out.last ? keep_wide : '1;

endmodule

/* hw/dma_stream_stage.sv */
/*
  One-deep valid/ready register stage
  Full throughput, payload type set by parameter
*/
`timescale 1ns/10ps

module dma_stream_stage #(
  parameter type payload_t = logic
) (
  input  logic     CLK,
  input  logic     dma_reset_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  payload_t data_r;
  logic     valid_r;

  // Empty, or the held beat leaves this cycle
  assign in_ready = ~valid_r | out_ready;

  always_ff @(posedge CLK) begin
    if (!dma_reset_n) begin
      valid_r <= 1'b0;
    end else if (in_ready) begin
      valid_r <= in_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_ready && in_valid)
      data_r <= in_data;
  end

  assign out_data  = data_r;
  assign out_valid = valid_r;

endmodule

/* hw/dma_top.sv */
/*
  DMA front end top level
  Register window, engine sequencer, C2S requester path and S2C completion path
*/
`timescale 1ns/10ps

module dma_top import dma_pkg::*; (
  input  logic                    CLK,
  input  logic                    dma_reset_n,
  // Register window
  input  logic                    mem_en,
  input  logic [addr_w-1:0]       mem_addr,
  input  logic [reg_data_w-1:0]   mem_din,
  input  logic [reg_data_w/8-1:0] mem_we,
  output logic [reg_data_w-1:0]   mem_dout,
  output logic                    mem_ack,
  // C2S user stream
  input  logic [bus_data_w-1:0]   c2s_tdata,
  input  logic [byte_keep_w-1:0]  c2s_tkeep,
  input  logic                    c2s_tlast,
  input  logic                    c2s_tvalid,
  output logic                    c2s_tready,
  // Requester stream
  output logic [bus_data_w-1:0]   rq_tdata,
  output logic [byte_keep_w-1:0]  rq_tkeep,
  output logic                    rq_tlast,
  output logic                    rq_tvalid,
  input  logic                    rq_tready,
  // Completion in, S2C out
  input  logic [bus_data_w-1:0]   rc_tdata,
  input  logic [dword_keep_w-1:0] rc_tkeep,
  input  logic                    rc_tlast,
  input  logic                    rc_tvalid,
  output logic                    rc_tready,
  output logic [bus_data_w-1:0]   s2c_tdata,
  output logic [byte_keep_w-1:0]  s2c_tkeep,
  output logic                    s2c_tlast,
  output logic                    s2c_tvalid,
  input  logic                    s2c_tready,
  // Status
  output logic                    irq,
  output logic                    operation_in_course
);

  logic                  core_reset_n;
  logic                  engine_enable, enable_write, irq_enable;
  logic [reg_data_w-1:0] descriptor_size, byte_count;
  logic                  running, done_pulse, size_reached;
  logic                  c2s_stage_valid, c2s_stage_ready;
  c2s_beat_t             c2s_in, c2s_out;

  dma_regs dma_regs_i (
    .CLK(CLK), .dma_reset_n(dma_reset_n),
    .mem_en(mem_en), .mem_addr(mem_addr), .mem_din(mem_din), .mem_we(mem_we),
    .done_pulse(done_pulse), .byte_count(byte_count),
    .mem_dout(mem_dout), .mem_ack(mem_ack), .core_reset_n(core_reset_n),
    .engine_enable(engine_enable), .enable_write(enable_write),
    .descriptor_size(descriptor_size), .irq_enable(irq_enable), .irq(irq)
  );

  dma_engine_fsm dma_engine_fsm_i (
    .CLK(CLK), .dma_reset_n(core_reset_n),
    .engine_enable(engine_enable), .enable_write(enable_write),
    .size_reached(size_reached), .rq_tready(rq_tready),
    .running(running), .done_pulse(done_pulse),
    .operation_in_course(operation_in_course)
  );

  //////////////////////
  // C2S to requester
  assign c2s_in = '{data: c2s_tdata, keep: c2s_tkeep, last: c2s_tlast};

  dma_stream_stage #(.payload_t(c2s_beat_t)) c2s_stage_i (
    .CLK(CLK), .dma_reset_n(core_reset_n),
    .in_data(c2s_in), .in_valid(c2s_tvalid), .in_ready(c2s_tready),
    .out_data(c2s_out), .out_valid(c2s_stage_valid), .out_ready(c2s_stage_ready)
  );

  dma_transfer_counter dma_transfer_counter_i (
    .CLK(CLK), .dma_reset_n(core_reset_n),
    .running(running), .enable_write(enable_write),
    .descriptor_size(descriptor_size),
    .stage_valid(c2s_stage_valid), .stage_keep(c2s_out.keep),
    .rq_tready(rq_tready), .rq_tvalid(rq_tvalid), .stage_ready(c2s_stage_ready),
    .byte_count(byte_count), .size_reached(size_reached)
  );

  assign rq_tdata = c2s_out.data;
  assign rq_tkeep = c2s_out.keep;
  assign rq_tlast = c2s_out.last;

  //////////////////////
  // Completion to S2C
  dma_s2c_path dma_s2c_path_i (
    .CLK(CLK), .dma_reset_n(core_reset_n),
    .rc_tdata(rc_tdata), .rc_tkeep(rc_tkeep), .rc_tlast(rc_tlast),
    .rc_tvalid(rc_tvalid), .rc_tready(rc_tready),
    .s2c_tdata(s2c_tdata), .s2c_tkeep(s2c_tkeep), .s2c_tlast(s2c_tlast),
    .s2c_tvalid(s2c_tvalid), .s2c_tready(s2c_tready)
  );

endmodule

/* hw/dma_transfer_counter.sv */
/*
  C2S byte counter
  Gates the requester stream while running and sums transferred keep bytes
*/
`timescale 1ns/10ps

module dma_transfer_counter import dma_pkg::*; (
  input  logic                   CLK,
  input  logic                   dma_reset_n,
  input  logic                   running,
  input  logic                   enable_write,
  input  logic [reg_data_w-1:0]  descriptor_size,
  input  logic                   stage_valid,
  input  logic [byte_keep_w-1:0] stage_keep,
  input  logic                   rq_tready,
  output logic                   rq_tvalid,
  output logic                   stage_ready,
  output logic [reg_data_w-1:0]  byte_count,
  output logic                   size_reached
);

  logic                  pass;
  logic [keep_cnt_w-1:0] keep_count;

  assign size_reached = (byte_count >= descriptor_size);
  assign pass         = running & ~size_reached;  // No beat past the size

  assign rq_tvalid   = stage_valid & pass;
  assign stage_ready = rq_tready & pass;

  always_comb begin
    keep_count = '0;
    for (int i = 0; i < byte_keep_w; i++)
      keep_count = keep_count + keep_cnt_w'(stage_keep[i]);
  end

  always_ff @(posedge CLK) begin
    if (!dma_reset_n) begin
      byte_count <= '0;
    end else if (enable_write) begin
      byte_count <= '0;  // New descriptor
    end else if (rq_tvalid && rq_tready) begin
      byte_count <= byte_count + reg_data_w'(keep_count);
    end
  end

endmodule

/* tests/dma_assertions.sv */
/*
  DMA front end protocol assertions
  Stream hold, interrupt gating and register ack timing
*/
`timescale 1ns/10ps

module dma_assertions import dma_pkg::*; (
  input logic                  CLK,
  input logic                  core_reset_n,
  input logic                  mem_en,
  input logic [addr_w-1:0]     mem_addr,
  input logic                  mem_ack,
  input logic [bus_data_w-1:0] rq_tdata,
  input logic                  rq_tvalid,
  input logic                  rq_tready,
  input logic [bus_data_w-1:0] s2c_tdata,
  input logic                  s2c_tvalid,
  input logic                  s2c_tready,
  input logic                  irq,
  input logic                  irq_enable,
  input logic                  operation_in_course
);

  int assertion_failures = 0;  // Failed assertion count

  rq_valid_holds: assert property (@(posedge CLK) disable iff (!core_reset_n)
    rq_tvalid && !rq_tready |=> rq_tvalid && $stable(rq_tdata))
    else begin
      assertion_failures++;
      $error("requester valid dropped or data changed before ready");
    end

  s2c_valid_holds: assert property (@(posedge CLK) disable iff (!core_reset_n)
    s2c_tvalid && !s2c_tready |=> s2c_tvalid && $stable(s2c_tdata))
    else begin
      assertion_failures++;
      $error("S2C valid dropped or data changed before ready");
    end

  // Interrupt rises only when enabled and after an engine end or a register write
  irq_gated: assert property (@(posedge CLK) disable iff (!core_reset_n)
    $rose(irq) |-> irq_enable && ($past(operation_in_course) || $past(mem_en)))
    else begin
      assertion_failures++;
      $error("irq rose while irq enable was low or with no engine end or write before it");
    end

  ack_follows_strobe: assert property (@(posedge CLK) disable iff (!core_reset_n)
    mem_ack |-> $past(mem_en))
    else begin
      assertion_failures++;
      $error("mem_ack without mem_en one cycle earlier");
    end

  global_acked: assert property (@(posedge CLK) disable iff (!core_reset_n)
    mem_en && (mem_addr == global_reg_addr) |=> mem_ack)
    else begin
      assertion_failures++;
      $error("global register access not acked after one cycle");
    end

endmodule

bind dma_top dma_assertions dma_assertions_i (
  .CLK                (CLK),
  .core_reset_n       (core_reset_n),
  .mem_en             (mem_en),
  .mem_addr           (mem_addr),
  .mem_ack            (mem_ack),
  .rq_tdata           (rq_tdata),
  .rq_tvalid          (rq_tvalid),
  .rq_tready          (rq_tready),
  .s2c_tdata          (s2c_tdata),
  .s2c_tvalid         (s2c_tvalid),
  .s2c_tready         (s2c_tready),
  .irq                (irq),
  .irq_enable         (irq_enable),
  .operation_in_course(operation_in_course)
);

/* tests/dma_checker.sv */
/*
  DMA front end checker
  Register model with expected read values, stream scoreboards for the
  requester and S2C paths, keep widening reference and error counts
*/
`timescale 1ns/10ps

module dma_checker import dma_pkg::*; (
  input logic                    CLK,
  input logic                    dma_reset_n,
  input logic                    mem_en,
  input logic [addr_w-1:0]       mem_addr,
  input logic [reg_data_w-1:0]   mem_din,
  input logic [reg_data_w/8-1:0] mem_we,
  input logic [reg_data_w-1:0]   mem_dout,
  input logic                    mem_ack,
  input logic [bus_data_w-1:0]   c2s_tdata,
  input logic [byte_keep_w-1:0]  c2s_tkeep,
  input logic                    c2s_tlast,
  input logic                    c2s_tvalid,
  input logic                    c2s_tready,
  input logic [bus_data_w-1:0]   rq_tdata,
  input logic [byte_keep_w-1:0]  rq_tkeep,
  input logic                    rq_tlast,
  input logic                    rq_tvalid,
  input logic                    rq_tready,
  input logic [bus_data_w-1:0]   rc_tdata,
  input logic [dword_keep_w-1:0] rc_tkeep,
  input logic                    rc_tlast,
  input logic                    rc_tvalid,
  input logic                    rc_tready,
  input logic [bus_data_w-1:0]   s2c_tdata,
  input logic [byte_keep_w-1:0]  s2c_tkeep,
  input logic                    s2c_tlast,
  input logic                    s2c_tvalid,
  input logic                    s2c_tready,
  input logic                    irq,
  input logic                    operation_in_course
);

  string                 test_name = "reset";
  int                    value_errors = 0;
  int                    other_errors = 0;
  c2s_beat_t             c2s_q[$];
  rc_beat_t              rc_q[$];
  // Register model
  logic                  m_enable, m_stopped, m_irq_pend, m_irq_en;
  logic [reg_data_w-1:0] m_size, m_count;
  logic                  soft_req, prev_oic, ack_due, exp_check;
  logic [reg_data_w-1:0] exp_read;

  //////////////////////
  // Reference functions
  function automatic int keep_bytes(input logic [byte_keep_w-1:0] keep);
    int n;
    n = 0;
    for (int i = 0; i < byte_keep_w; i++)
      if (keep[i])
        n++;
    return n;
  endfunction

  function automatic logic [byte_keep_w-1:0] widen_keep(input logic [dword_keep_w-1:0] dw,
                                                        input logic last);
    logic [byte_keep_w-1:0] b;
    b = '1;  // Full beat unless last
    if (last)
      for (int i = 0; i < byte_keep_w; i++)
        b[i] = dw[i / 4];
    return b;
  endfunction

  function automatic logic is_mapped(input logic [addr_w-1:0] addr);
    return addr == engine_ctrl_addr || addr == engine_size_addr ||
           addr == engine_count_addr || addr == global_reg_addr;
  endfunction

  function automatic logic [reg_data_w-1:0] reg_read_value(input logic [addr_w-1:0] addr);
    logic [reg_data_w-1:0] v;
    v = '0;
    if (addr == engine_ctrl_addr)
      v[7:0] = {m_irq_pend, 3'b000, m_stopped, 2'b00, m_enable};
    else if (addr == engine_size_addr)
      v = m_size;
    else if (addr == engine_count_addr)
      v = m_count;
    else if (addr == global_reg_addr)
      v[7:0] = {1'b0, m_irq_en, 3'(12 - 7), 3'(8 - 7)};  // Log2 codes minus 7
    return v;
  endfunction

  //////////////////////
  // Reporting
  task automatic begin_test(input string name);
    test_name = name;
  endtask

  task automatic check_value(input string what, input logic [bus_data_w-1:0] exp,
                             input logic [bus_data_w-1:0] act);
    if (exp !== act) begin
      value_errors++;
      $display("ERROR %s %s expected %0h actual %0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    other_errors++;
    $display("Failure in %s: %s", test_name, what);
  endtask

  task automatic print_counts(input int assertion_fails, output int all_errors);
    if (c2s_q.size() != 0)
      report_failure("C2S beats never reached the requester stream");
    if (rc_q.size() != 0)
      report_failure("completion beats never reached the S2C stream");
    all_errors = value_errors + other_errors + assertion_fails;
    $display("Error counts: %0d wrong values, %0d other failures, %0d assertion failures",
             value_errors, other_errors, assertion_fails);
  endtask

  task automatic clear_model();
    m_enable   = 1'b0;
    m_stopped  = 1'b0;
    m_irq_pend = 1'b0;
    m_irq_en   = 1'b0;
    m_size     = '0;
    m_count    = '0;
  endtask

  task automatic apply_write(input logic [addr_w-1:0] addr, input logic [reg_data_w-1:0] din,
                             input logic [reg_data_w/8-1:0] we);
    if (addr == engine_ctrl_addr && we[0]) begin
      m_enable = din[st_enable_bit];
      if (din[st_enable_bit]) begin
        m_stopped = 1'b0;
        m_count   = '0;  // New descriptor
      end
      if (din[st_irq_bit])
        m_irq_pend = 1'b0;
    end
    if (addr == engine_size_addr)
      for (int i = 0; i < reg_data_w / 8; i++)
        if (we[i])
          m_size[8*i +: 8] = din[8*i +: 8];
    if (addr == global_reg_addr && we[0]) begin
      m_irq_en = din[gl_irq_en_bit];
      if (din[gl_soft_reset_bit])
        soft_req = 1'b1;
    end
  endtask

  //////////////////////
  // Compare process
  always @(posedge CLK) begin
    c2s_beat_t c2s_exp;
    rc_beat_t  rc_exp;
    if (!dma_reset_n) begin
      clear_model();
      c2s_q.delete();
      rc_q.delete();
      soft_req = 1'b0;
      prev_oic = 1'b0;
      ack_due  = 1'b0;
    end else begin
      // Engine end is seen one edge after the FSM leaves drain
      if (prev_oic && !operation_in_course) begin
        m_stopped  = 1'b1;
        m_irq_pend = 1'b1;
      end
      prev_oic = operation_in_course;
      check_value("irq", m_irq_pend & m_irq_en, irq);

      if (ack_due && !mem_ack)
        report_failure("mapped register access got no ack");
      else if (!ack_due && mem_ack)
        report_failure("mem_ack without a mapped request");
      else if (mem_ack && exp_check)
        check_value("read data", exp_read, mem_dout);

      if (rq_tvalid && rq_tready) begin
        if (c2s_q.size() == 0) begin
          report_failure("requester beat with no C2S beat behind it");
        end else begin
          c2s_exp = c2s_q.pop_front();
          check_value("rq data", c2s_exp.data, rq_tdata);
          check_value("rq keep", c2s_exp.keep, rq_tkeep);
          check_value("rq last", c2s_exp.last, rq_tlast);
          m_count = m_count + reg_data_w'(keep_bytes(c2s_exp.keep));
        end
      end
      if (c2s_tvalid && c2s_tready)
        c2s_q.push_back({c2s_tdata, c2s_tkeep, c2s_tlast});

      if (s2c_tvalid && s2c_tready) begin
        if (rc_q.size() == 0) begin
          report_failure("S2C beat with no completion beat behind it");
        end else begin
          rc_exp = rc_q.pop_front();
          check_value("s2c data", rc_exp.data, s2c_tdata);
          check_value("s2c keep", widen_keep(rc_exp.keep, rc_exp.last), s2c_tkeep);
          check_value("s2c last", rc_exp.last, s2c_tlast);
        end
      end
      if (rc_tvalid && rc_tready)
        rc_q.push_back({rc_tdata, rc_tkeep, rc_tlast});

      if (soft_req) begin  // Core reset lands one edge after the write
        clear_model();
        soft_req = 1'b0;
      end

      ack_due = 1'b0;
      if (mem_en) begin
        ack_due   = is_mapped(mem_addr);
        exp_read  = reg_read_value(mem_addr);
        exp_check = (mem_we == '0);
        if (mem_we != '0)
          apply_write(mem_addr, mem_din, mem_we);
      end
    end
  end

endmodule

/* tests/dma_tb.sv */
/*
  DMA front end testbench
  Clock, reset, register sequences, C2S and completion traffic, watchdog
*/
`timescale 1ns/10ps

module dma_tb import dma_pkg::*; ();

  localparam int c2s_beats    = 12;
  localparam int rc_beats     = 40;
  localparam int reg_accesses = 24;
  localparam int limit_cycles = (2 * c2s_beats + rc_beats + reg_accesses) * 20 + 400;

  logic                    CLK;
  logic                    dma_reset_n;
  logic                    mem_en;
  logic [addr_w-1:0]       mem_addr;
  logic [reg_data_w-1:0]   mem_din;
  logic [reg_data_w/8-1:0] mem_we;
  logic [reg_data_w-1:0]   mem_dout;
  logic                    mem_ack;
  logic [bus_data_w-1:0]   c2s_tdata, rq_tdata, rc_tdata, s2c_tdata;
  logic [byte_keep_w-1:0]  c2s_tkeep, rq_tkeep, s2c_tkeep;
  logic [dword_keep_w-1:0] rc_tkeep;
  logic                    c2s_tlast, c2s_tvalid, c2s_tready;
  logic                    rq_tlast, rq_tvalid, rq_tready;
  logic                    rc_tlast, rc_tvalid, rc_tready;
  logic                    s2c_tlast, s2c_tvalid, s2c_tready;
  logic                    irq, operation_in_course;
  integer                  seed;
  logic [byte_keep_w-1:0]  c2s_keep_a [c2s_beats];
  int                      all_errors;

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;  // 20 ns period

  dma_top dma_top_i (.*);

  dma_checker checker_i (.*);

  // Random back-pressure on both output streams
  always @(posedge CLK) begin
    rq_tready  <= ($random(seed) & 3) != 0;
    s2c_tready <= ($random(seed) & 3) != 0;
  end

  function automatic logic [bus_data_w-1:0] random_data();
    logic [bus_data_w-1:0] d;
    for (int i = 0; i < bus_data_w / 32; i++)
      d[32*i +: 32] = $random(seed);
    return d;
  endfunction

  //////////////////////
  // Register access, ack due exactly one cycle after the strobe
  task automatic reg_access(input logic [addr_w-1:0] addr, input logic [reg_data_w-1:0] data,
                            input logic [reg_data_w/8-1:0] we);
    @(posedge CLK);
    mem_en   <= 1'b1;
    mem_addr <= addr;
    mem_din  <= data;
    mem_we   <= we;
    @(posedge CLK);
    mem_en <= 1'b0;
    mem_we <= '0;
    @(posedge CLK);  // Checker compares the ack here
  endtask

  task automatic reg_write(input logic [addr_w-1:0] addr, input logic [reg_data_w-1:0] data);
    reg_access(addr, data, '1);
  endtask

  task automatic reg_read(input logic [addr_w-1:0] addr);
    reg_access(addr, '0, '0);
  endtask

  //////////////////////
  // Streams
  task automatic pick_c2s_keeps(output logic [reg_data_w-1:0] total);
    total = '0;
    for (int i = 0; i < c2s_beats; i++) begin
      c2s_keep_a[i] = $random(seed);
      if (i == c2s_beats - 1)
        c2s_keep_a[i][0] = 1'b1;  // Last beat is the one that reaches the size
      total = total + reg_data_w'($countones(c2s_keep_a[i]));
    end
  endtask

  task automatic send_c2s();
    for (int i = 0; i < c2s_beats; i++) begin
      c2s_tvalid <= 1'b1;
      c2s_tdata  <= random_data();
      c2s_tkeep  <= c2s_keep_a[i];
      c2s_tlast  <= (i == c2s_beats - 1);
      do @(posedge CLK); while (!c2s_tready);
    end
    c2s_tvalid <= 1'b0;
  endtask

  task automatic send_rc();
    for (int i = 0; i < rc_beats; i++) begin
      rc_tvalid <= 1'b1;
      rc_tdata  <= random_data();
      rc_tkeep  <= dword_keep_w'($random(seed));
      rc_tlast  <= (($random(seed) & 3) == 0) || (i == rc_beats - 1);
      do @(posedge CLK); while (!rc_tready);
    end
    rc_tvalid <= 1'b0;
  endtask

  task automatic wait_engine_idle();
    int waited;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
    end while (operation_in_course && waited < 40 * c2s_beats);
    if (operation_in_course)
      checker_i.report_failure("engine did not return to idle after the descriptor");
  endtask

  task automatic wait_s2c_drained();
    int waited;
    waited = 0;
    do begin
      @(posedge CLK);
      waited++;
    end while (s2c_tvalid && waited < 100);
    if (s2c_tvalid)
      checker_i.report_failure("S2C stream did not drain");
  endtask

  //////////////////////
  // Test sequence
  initial begin
    logic [reg_data_w-1:0] size;
    seed        = 45171;
    dma_reset_n = 1'b0;
    mem_en      = 1'b0;
    mem_addr    = '0;
    mem_din     = '0;
    mem_we      = '0;
    c2s_tdata   = '0;
    c2s_tkeep   = '0;
    c2s_tlast   = 1'b0;
    c2s_tvalid  = 1'b0;
    rq_tready   = 1'b0;
    rc_tdata    = '0;
    rc_tkeep    = '0;
    rc_tlast    = 1'b0;
    rc_tvalid   = 1'b0;
    s2c_tready  = 1'b0;
    repeat (3) @(posedge CLK);
    dma_reset_n <= 1'b1;

    checker_i.begin_test("global register");
    reg_write(global_reg_addr, 64'h40);  // irq enable
    reg_read(global_reg_addr);
    reg_read(16'h1234);                  // Unmapped, no ack
    reg_read(engine_ctrl_addr);

    checker_i.begin_test("descriptor transfer");
    pick_c2s_keeps(size);
    reg_write(engine_size_addr, size);
    reg_write(engine_ctrl_addr, 64'h01);
    send_c2s();
    wait_engine_idle();
    reg_read(engine_ctrl_addr);
    reg_read(engine_count_addr);
    reg_read(engine_size_addr);

    checker_i.begin_test("interrupt");
    checker_i.check_value("irq after done", 1, irq);
    reg_write(engine_ctrl_addr, 64'h80);  // Clear irq pending
    checker_i.check_value("irq after clear", 0, irq);
    reg_write(global_reg_addr, 64'h00);
    pick_c2s_keeps(size);
    reg_write(engine_size_addr, size);
    reg_write(engine_ctrl_addr, 64'h01);
    send_c2s();
    wait_engine_idle();
    @(posedge CLK);
    checker_i.check_value("irq while disabled", 0, irq);
    reg_read(engine_ctrl_addr);

    checker_i.begin_test("completion path");
    send_rc();
    wait_s2c_drained();

    checker_i.begin_test("soft reset");
    reg_write(global_reg_addr, 64'h40);
    reg_write(global_reg_addr, 64'h80);
    @(posedge CLK);
    reg_read(engine_size_addr);
    reg_read(global_reg_addr);
    reg_read(engine_ctrl_addr);
    reg_read(engine_count_addr);
    checker_i.check_value("operation_in_course", 0, operation_in_course);

    repeat (4) @(posedge CLK);
    checker_i.print_counts(dma_top_i.dma_assertions_i.assertion_failures, all_errors);
    if (all_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog sized from the beat and access counts
  initial begin
    #(limit_cycles * 20);
    checker_i.report_failure("watchdog timeout, test sequence did not finish");
    checker_i.print_counts(dma_top_i.dma_assertions_i.assertion_failures, all_errors);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
